// ==== tb.f ====
+incdir+common
+incdir+verification
common/alu_pkg.sv
hw/alu/cond_eval.sv
hw/alu/alu_exec.sv
hw/alu/alu_retire.sv
hw/alu/alu_top.sv
verification/tb_alu.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_alu

SRCS := $(filter-out +%,$(shell cat tb.f)) common/alu_cfg.svh verification/alu_ref.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) tb.f
	verilator --binary --timing --assert --top-module tb_alu -f tb.f

# pass only if the testbench printed the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== verification/alu_ref.svh ====
// execute unit reference model

`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// result at the selected width, 32-bit forms clear the upper half
function automatic alu_pkg::word_t result_of(input alu_pkg::op_e o, input logic w,
                                             input alu_pkg::word_t x, input alu_pkg::word_t y,
                                             input logic take);
  alu_pkg::word_t r;
  case (o)
    alu_pkg::ADD:   r = x + y;
    alu_pkg::SUB:   r = x - y;
    alu_pkg::AND:   r = x & y;
    alu_pkg::OR:    r = x | y;
    alu_pkg::XOR:   r = x ^ y;
    alu_pkg::XNOR:  r = ~(x ^ y);
    alu_pkg::MOV:   r = y;
    alu_pkg::ZXT8:  r = 64'(y[7:0]);
    alu_pkg::ZXT16: r = 64'(y[15:0]);
    alu_pkg::SXT8:  r = 64'($signed(y[7:0]));
    alu_pkg::SXT16: r = 64'($signed(y[15:0]));
    alu_pkg::SXT32: r = 64'($signed(y[31:0]));
    alu_pkg::CMOV:  r = take ? y : x;
    alu_pkg::CSET:  r = take ? 64'd1 : 64'd0;
    default:        r = '0;
  endcase
  return w ? r : (r & 64'h0000_0000_ffff_ffff);
endfunction

function automatic alu_pkg::flags_t flags_of(input alu_pkg::op_e o, input logic w,
                                             input alu_pkg::word_t x, input alu_pkg::word_t y);
  alu_pkg::word_t r;
  logic [64:0]    s65;
  logic [32:0]    s33;
  logic [4:0]     nib;
  logic           sx;
  logic           sy;
  logic           sr;
  logic           cy;
  logic           ov;
  logic           ax;
  r   = result_of(o, w, x, y, 1'b0);
  s65 = {1'b0, x} + {1'b0, y};
  s33 = {1'b0, x[31:0]} + {1'b0, y[31:0]};
  nib = {1'b0, x[3:0]} + {1'b0, y[3:0]};
  sx  = w ? x[63] : x[31];
  sy  = w ? y[63] : y[31];
  sr  = w ? r[63] : r[31];
  if (o == alu_pkg::ADD) begin
    cy = w ? s65[64] : s33[32];
    ov = (sx == sy) && (sr != sx);
    ax = nib[4];
  end else begin
    cy = w ? (x >= y) : (x[31:0] >= y[31:0]);  // no borrow
    ov = (sx != sy) && (sr != sx);
    ax = x[3:0] < y[3:0];  // nibble borrow
  end
  if (o == alu_pkg::ADD || o == alu_pkg::SUB)
    return {cy, ov, ax, sr, r == '0, 1'b0};
  if (o == alu_pkg::AND || o == alu_pkg::OR || o == alu_pkg::XOR || o == alu_pkg::XNOR)
    return {3'b000, sr, r == '0, 1'b0};
  return '0;
endfunction

// c o a s z p from bit 5 down to bit 0
function automatic logic cond_holds(input alu_pkg::flags_t f, input alu_pkg::cond_t c);
  case (alu_pkg::cond_e'(c))
    alu_pkg::Z:   return f[1];
    alu_pkg::NZ:  return !f[1];
    alu_pkg::S:   return f[2];
    alu_pkg::NS:  return !f[2];
    alu_pkg::UGT: return f[5] && !f[1];
    alu_pkg::ULE: return !f[5] || f[1];
    alu_pkg::UGE: return f[5];
    alu_pkg::ULT: return !f[5];
    alu_pkg::SGT: return !f[1] && (f[2] == f[4]);
    alu_pkg::SLE: return f[1] || (f[2] != f[4]);
    alu_pkg::SGE: return f[2] == f[4];
    alu_pkg::SLT: return f[2] != f[4];
    alu_pkg::O:   return f[4];
    alu_pkg::NO:  return !f[4];
    alu_pkg::P:   return f[0];
    default:      return 1'b1;  // np
  endcase
endfunction

`endif

// ==== verification/tb_alu.sv ====
// execute unit testbench

`timescale 1ns/1ps

module tb_alu;

  localparam int OP_COUNT = 730;  // directed ops, two clocks each

  logic            clk;
  logic            rst;
  logic            valid;
  alu_pkg::op_e    op;
  logic            w64;
  logic            set_flags;
  alu_pkg::cond_t  cond;
  alu_pkg::word_t  a;
  alu_pkg::word_t  b;
  alu_pkg::flags_t flags_in;
  logic            thread;
  logic            except;
  logic            except_thread;
  alu_pkg::word_t  result;
  alu_pkg::flags_t flags;
  logic            flags_wr;
  logic            ret_en;
  int              errors;
  int              checks;

  `include "alu_ref.svh"

  alu_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .op            (op),
    .w64           (w64),
    .set_flags     (set_flags),
    .cond          (cond),
    .a             (a),
    .b             (b),
    .flags_in      (flags_in),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .result        (result),
    .flags         (flags),
    .flags_wr      (flags_wr),
    .ret_en        (ret_en)
  );

  always #5 clk = ~clk;

  task automatic check(input alu_pkg::word_t got, input alu_pkg::word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic alu_pkg::word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // one op in, result checked one edge later
  task automatic exec_and_check(input alu_pkg::op_e o, input logic w, input logic sf,
                                input alu_pkg::cond_t cc, input alu_pkg::word_t x,
                                input alu_pkg::word_t y, input alu_pkg::flags_t fi);
    alu_pkg::word_t  exp_r;
    alu_pkg::flags_t exp_f;
    string           tag;
    exp_r = result_of(o, w, x, y, cond_holds(fi, cc));
    exp_f = flags_of(o, w, x, y);
    tag   = $sformatf("%s w64=%0b cond=%0d a=%h b=%h", o.name(), w, cc, x, y);
    @(posedge clk);
    valid     <= 1'b1;
    op        <= o;
    w64       <= w;
    set_flags <= sf;
    cond      <= cc;
    a         <= x;
    b         <= y;
    flags_in  <= fi;
    @(posedge clk);
    valid <= 1'b0;
    #1;
    check(result, exp_r, {tag, " result"});
    check(64'(flags), 64'(exp_f), {tag, " flags"});
    check(64'(ret_en), 64'd1, {tag, " ret_en"});
    check(64'(flags_wr), 64'(sf), {tag, " flags_wr"});
  endtask

  task automatic test_arith();
    alu_pkg::word_t edges [6];
    alu_pkg::op_e   o;
    edges = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
              64'h8000_0000_0000_0000, 64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000};
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 2; s++) begin
        o = s[0] ? alu_pkg::SUB : alu_pkg::ADD;
        foreach (edges[i]) begin
          foreach (edges[j]) begin
            exec_and_check(o, w[0], i[0] ^ j[0], '0, edges[i], edges[j], '0);
          end
        end
        for (int n = 0; n < 20; n++) begin
          exec_and_check(o, w[0], 1'($urandom), '0, rand_word(), rand_word(), '0);
        end
      end
    end
  endtask

  task automatic test_logic();
    for (int w = 0; w < 2; w++) begin
      for (int k = 2; k <= 5; k++) begin  // and, or, xor, xnor
        for (int n = 0; n < 20; n++) begin
          exec_and_check(alu_pkg::op_e'(k), w[0], 1'b1, '0, rand_word(), rand_word(), '0);
          if (w == 0)
            check(64'(result[63:32]), 64'd0, "upper half in 32-bit logic op");
        end
      end
    end
  endtask

  task automatic test_extend();
    for (int w = 0; w < 2; w++) begin
      for (int k = 6; k <= 11; k++) begin  // mov up to sxt32
        for (int n = 0; n < 10; n++) begin
          exec_and_check(alu_pkg::op_e'(k), w[0], 1'b0, '0, rand_word(), rand_word(), '0);
        end
      end
    end
  endtask

  task automatic test_cond();
    alu_pkg::flags_t f;
    for (int c = 0; c < 16; c++) begin
      for (int n = 0; n < 6; n++) begin
        f = alu_pkg::flags_t'($urandom);
        exec_and_check(alu_pkg::CSET, 1'b1, 1'b0, alu_pkg::cond_t'(c), rand_word(),
                       rand_word(), f);
        exec_and_check(alu_pkg::CMOV, n[0], 1'b0, alu_pkg::cond_t'(c), rand_word(),
                       rand_word(), f);
      end
    end
  endtask

  // drive one cycle and check what the previous cycle retired
  task automatic retire_step(input logic v, input logic th, input logic ex,
                             input logic ex_th, input logic exp_ret, input string what);
    @(posedge clk);
    valid         <= v;
    thread        <= th;
    except        <= ex;
    except_thread <= ex_th;
    #1;
    check(64'(ret_en), 64'(exp_ret), {what, " ret_en"});
    check(64'(flags_wr), 64'(exp_ret), {what, " flags_wr"});
  endtask

  task automatic test_retire();
    @(posedge clk);
    op        <= alu_pkg::ADD;
    set_flags <= 1'b1;
    valid     <= 1'b0;
    retire_step(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, "idle");
    retire_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, "op with same-thread exception");
    retire_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, "op one cycle after exception");
    retire_step(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, "op two cycles after exception");
    retire_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, "op with other-thread exception");
    retire_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "no valid after exception");
    retire_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "no valid");
  endtask

  task automatic test_back_to_back();
    alu_pkg::word_t exp_q [$];
    alu_pkg::word_t x;
    alu_pkg::word_t y;
    alu_pkg::op_e   o;
    // reset with an op held at the inputs
    @(posedge clk);
    rst   <= 1'b1;
    valid <= 1'b1;
    repeat (2) begin
      @(posedge clk);
      #1;
      check(64'(ret_en), 64'd0, "ret_en while reset held");
    end
    @(posedge clk);
    rst   <= 1'b0;
    valid <= 1'b0;
    #1;
    check(64'(ret_en), 64'd0, "ret_en on last reset edge");
    for (int i = 0; i <= 16; i++) begin
      @(posedge clk);
      if (i < 16) begin
        x = rand_word();
        y = rand_word();
        o = (i % 2 == 0) ? alu_pkg::ADD : alu_pkg::SUB;
        valid <= 1'b1;
        op    <= o;
        w64   <= i[1];
        a     <= x;
        b     <= y;
        exp_q.push_back(result_of(o, i[1], x, y, 1'b0));
      end else begin
        valid <= 1'b0;
      end
      #1;
      if (i > 0) begin
        check(result, exp_q.pop_front(), $sformatf("back-to-back op %0d result", i - 1));
        check(64'(ret_en), 64'd1, $sformatf("back-to-back op %0d ret_en", i - 1));
      end
    end
  endtask

  initial begin
    #(OP_COUNT * 20 + 2000);
    $display("timeout: the tests did not finish in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(50));
    errors        = 0;
    checks        = 0;
    clk           = 1'b0;
    rst           = 1'b1;
    valid         = 1'b0;
    op            = alu_pkg::ADD;
    w64           = 1'b1;
    set_flags     = 1'b0;
    cond          = '0;
    a             = '0;
    b             = '0;
    flags_in      = '0;
    thread        = 1'b0;
    except        = 1'b0;
    except_thread = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_arith();
    test_logic();
    test_extend();
    test_cond();
    test_retire();
    test_back_to_back();
    @(posedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== hw/alu/alu_top.sv ====
// integer execute unit top

`timescale 1ns/1ps

module alu_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid,
  input  alu_pkg::op_e    op,
  input  logic            w64,        // low selects 32-bit form
  input  logic            set_flags,
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::word_t  a,
  input  alu_pkg::word_t  b,
  input  alu_pkg::flags_t flags_in,
  input  logic            thread,
  input  logic            except,
  input  logic            except_thread,
  output alu_pkg::word_t  result,
  output alu_pkg::flags_t flags,
  output logic            flags_wr,
  output logic            ret_en
);

  // issue inputs at edge N show up on the outputs after edge N+1
  logic            take;
  alu_pkg::word_t  result_d;
  alu_pkg::flags_t flags_d;

  cond_eval u_cond (
    .flags_in (flags_in),
    .cond     (cond),
    .take     (take)
  );

  alu_exec u_exec (
    .op       (op),
    .w64      (w64),
    .a        (a),
    .b        (b),
    .take     (take),
    .result_d (result_d),
    .flags_d  (flags_d)
  );

  alu_retire u_retire (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .set_flags     (set_flags),
    .result_d      (result_d),
    .flags_d       (flags_d),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .result        (result),
    .flags         (flags),
    .flags_wr      (flags_wr),
    .ret_en        (ret_en)
  );

endmodule

// ==== hw/alu/alu_retire.sv ====
// result register and retire inhibit

`timescale 1ns/1ps

module alu_retire (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid,
  input  logic            set_flags,
  input  alu_pkg::word_t  result_d,
  input  alu_pkg::flags_t flags_d,
  input  logic            thread,
  input  logic            except,
  input  logic            except_thread,
  output alu_pkg::word_t  result,
  output alu_pkg::flags_t flags,
  output logic            flags_wr,
  output logic            ret_en
);

  logic except_q;         // exception seen last cycle
  logic except_thread_q;
  logic hit_now;
  logic hit_prev;
  logic inhibit;

  // inhibit window is this cycle and the one before
  assign hit_now  = except && (thread == except_thread);
  assign hit_prev = except_q && (thread == except_thread_q);
  assign inhibit  = hit_now || hit_prev;

  always_ff @(posedge clk) begin
    if (rst) begin
      result          <= '0;
      flags           <= '0;
      ret_en          <= 1'b0;
      flags_wr        <= 1'b0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end else begin
      result          <= result_d;
      flags           <= flags_d;
      ret_en          <= valid & ~inhibit;
      flags_wr        <= valid & set_flags & ~inhibit;  // only retiring ops write flags
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

  // flag write without retire would corrupt the flag file
  a_wr_needs_ret: assert property (
    @(posedge clk) disable iff (rst)
    flags_wr |-> ret_en
  ) else $error("alu_retire: flags_wr without ret_en");

  a_no_ret_after_rst: assert property (
    @(posedge clk)
    rst |=> !ret_en
  ) else $error("alu_retire: ret_en high right after reset");

endmodule

// ==== hw/alu/alu_exec.sv ====
// execute datapath and flag generation

`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_exec (
  input  alu_pkg::op_e    op,
  input  logic            w64,
  input  alu_pkg::word_t  a,
  input  alu_pkg::word_t  b,
  input  logic            take,
  output alu_pkg::word_t  result_d,
  output alu_pkg::flags_t flags_d
);

  localparam int W = `ALU_WORD_W;
  localparam int H = `ALU_HALF_W;

  logic           is_sub;
  logic           is_arith;
  logic           is_logic;
  alu_pkg::word_t b_x;        // second adder input
  logic [W:0]     sum;
  logic           c_full;
  logic           c_half;
  logic           c_nib;      // out of bit 3
  logic           ovf_full;
  logic           ovf_half;
  alu_pkg::word_t logic_res;
  alu_pkg::word_t ext_res;
  alu_pkg::word_t full_res;   // before the width mask
  logic           res_s;
  logic           res_z;
  logic           flag_c;
  logic           flag_o;
  logic           flag_a;

  assign is_sub   = (op == alu_pkg::SUB);
  assign is_arith = (op == alu_pkg::ADD) || is_sub;
  assign is_logic = (op == alu_pkg::AND) || (op == alu_pkg::OR) ||
                    (op == alu_pkg::XOR) || (op == alu_pkg::XNOR);

  // shared adder, sub is a + ~b + 1
  assign b_x = is_sub ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, b_x} + {{W{1'b0}}, is_sub};

  // carry into bit k recovered as sum ^ a ^ b
  assign c_full = sum[W];
  assign c_half = sum[H] ^ a[H] ^ b_x[H];
  assign c_nib  = sum[4] ^ a[4] ^ b_x[4];

  assign ovf_full = (a[W-1] == b_x[W-1]) && (sum[W-1] != a[W-1]);
  assign ovf_half = (a[H-1] == b_x[H-1]) && (sum[H-1] != a[H-1]);

  always_comb begin
    case (op)
      alu_pkg::AND:  logic_res = a & b;
      alu_pkg::OR:   logic_res = a | b;
      alu_pkg::XOR:  logic_res = a ^ b;
      default:       logic_res = ~(a ^ b);  // xnor
    endcase
  end

  // move and extend, all from b
  always_comb begin
    case (op)
      alu_pkg::ZXT8:  ext_res = {{(W-8){1'b0}}, b[7:0]};
      alu_pkg::ZXT16: ext_res = {{(W-16){1'b0}}, b[15:0]};
      alu_pkg::SXT8:  ext_res = {{(W-8){b[7]}}, b[7:0]};
      alu_pkg::SXT16: ext_res = {{(W-16){b[15]}}, b[15:0]};
      alu_pkg::SXT32: ext_res = {{(W-32){b[31]}}, b[31:0]};
      default:        ext_res = b;
    endcase
  end

  always_comb begin
    case (op)
      alu_pkg::ADD,
      alu_pkg::SUB:   full_res = sum[W-1:0];
      alu_pkg::AND,
      alu_pkg::OR,
      alu_pkg::XOR,
      alu_pkg::XNOR:  full_res = logic_res;
      alu_pkg::MOV,
      alu_pkg::ZXT8,
      alu_pkg::ZXT16,
      alu_pkg::SXT8,
      alu_pkg::SXT16,
      alu_pkg::SXT32: full_res = ext_res;
      alu_pkg::CMOV:  full_res = take ? b : a;
      alu_pkg::CSET:  full_res = {{(W-1){1'b0}}, take};
      default:        full_res = '0;
    endcase
  end

  // 32-bit forms clear the upper half
  assign result_d = w64 ? full_res : {{(W-H){1'b0}}, full_res[H-1:0]};

  assign res_s = w64 ? result_d[W-1] : result_d[H-1];
  assign res_z = ~|result_d;  // upper half already zero in 32-bit form

  assign flag_c = w64 ? c_full : c_half;
  assign flag_o = w64 ? ovf_full : ovf_half;
  assign flag_a = c_nib ^ is_sub;

  always_comb begin
    if (is_arith) begin
      flags_d = {flag_c, flag_o, flag_a, res_s, res_z, 1'b0};
    end else if (is_logic) begin
      flags_d = {3'b000, res_s, res_z, 1'b0};
    end else begin
      flags_d = '0;
    end
  end

  always_comb begin
    assert (!$isunknown(op))
      else $error("alu_exec: unknown operation code");
  end

endmodule

// ==== hw/alu/cond_eval.sv ====
// condition code decoder

`timescale 1ns/1ps

module cond_eval (
  input  alu_pkg::flags_t flags_in,
  input  alu_pkg::cond_t  cond,
  output logic            take
);

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;
  logic lt;  // signed less than

  assign c  = flags_in[5];  // set means no borrow
  assign o  = flags_in[4];
  assign s  = flags_in[2];
  assign z  = flags_in[1];
  assign p  = flags_in[0];
  assign lt = s ^ o;

  always_comb begin
    case (alu_pkg::cond_e'(cond))
      alu_pkg::Z:   take = z;
      alu_pkg::NZ:  take = ~z;
      alu_pkg::S:   take = s;
      alu_pkg::NS:  take = ~s;
      alu_pkg::UGT: take = c & ~z;
      alu_pkg::ULE: take = ~c | z;
      alu_pkg::UGE: take = c;
      alu_pkg::ULT: take = ~c;
      alu_pkg::SGT: take = ~(lt | z);
      alu_pkg::SLE: take = lt | z;
      alu_pkg::SGE: take = ~lt;
      alu_pkg::SLT: take = lt;
      alu_pkg::O:   take = o;
      alu_pkg::NO:  take = ~o;
      alu_pkg::P:   take = p;
      alu_pkg::NP:  take = 1'b1;  // always, p is never set
      default:      take = 1'b1;
    endcase
  end

endmodule

// ==== common/alu_pkg.sv ====
// alu shared types

`include "alu_cfg.svh"

package alu_pkg;

  typedef logic [`ALU_WORD_W-1:0] word_t;
  typedef logic [`ALU_FLAG_W-1:0] flags_t;  // c o a s z p, high to low
  typedef logic [`ALU_COND_W-1:0] cond_t;

  // encoding follows the order
  typedef enum logic [`ALU_COND_W-1:0] {
    Z,
    NZ,
    S,
    NS,
    UGT,
    ULE,
    UGE,
    ULT,
    SGT,
    SLE,
    SGE,
    SLT,
    O,
    NO,
    P,
    NP
  } cond_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    XNOR,
    MOV,
    ZXT8,
    ZXT16,
    SXT8,
    SXT16,
    SXT32,
    CMOV,
    CSET
  } op_e;

endpackage

// ==== common/alu_cfg.svh ====
// alu width configuration

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// operand and result width
`define ALU_WORD_W 64

// 32-bit instruction forms
`define ALU_HALF_W 32

// c o a s z p
`define ALU_FLAG_W 6

// condition code, sixteen codes
`define ALU_COND_W 4

`endif
